/* state_display_pkg.sv */
`default_nettype none

package state_display_pkg;

    localparam int SEG_W        = 7;
    localparam int DIGIT_COUNT  = 8;
    localparam int DIGIT_IDX_W  = 3;
    localparam int PROBE_W      = 16;
    localparam int LABEL_DIGITS = 4;
    localparam int VALUE_DIGITS = 4;

    typedef logic [SEG_W-1:0] glyph_t;                 // active low with segment g at msb
    typedef glyph_t [LABEL_DIGITS-1:0] glyph_quad_t;   // [0] is the rightmost digit

    // one probe word read as hex or as a control-unit state code
    typedef union packed {
        logic [VALUE_DIGITS-1:0][3:0] nibbles;
        struct packed {
            logic [7:0] upper;                         // zero for a valid state
            logic [3:0] phase;
            logic [1:0] variant;
            logic [1:0] step;
        } state;
    } probe_word_u;

    localparam glyph_t GLYPH_BLANK   = 7'b111_1111;

    localparam glyph_t GLYPH_HEX_0   = 7'b100_0000;
    localparam glyph_t GLYPH_HEX_1   = 7'b111_1001;
    localparam glyph_t GLYPH_HEX_2   = 7'b010_0100;
    localparam glyph_t GLYPH_HEX_3   = 7'b011_0000;
    localparam glyph_t GLYPH_HEX_4   = 7'b001_1001;
    localparam glyph_t GLYPH_HEX_5   = 7'b001_0010;
    localparam glyph_t GLYPH_HEX_6   = 7'b000_0010;
    localparam glyph_t GLYPH_HEX_7   = 7'b111_1000;
    localparam glyph_t GLYPH_HEX_8   = 7'b000_0000;
    localparam glyph_t GLYPH_HEX_9   = 7'b001_1000;
    localparam glyph_t GLYPH_HEX_A   = 7'b000_1000;
    localparam glyph_t GLYPH_HEX_B   = 7'b000_0011;
    localparam glyph_t GLYPH_HEX_C   = 7'b100_0110;
    localparam glyph_t GLYPH_HEX_D   = 7'b010_0001;
    localparam glyph_t GLYPH_HEX_E   = 7'b000_0110;
    localparam glyph_t GLYPH_HEX_F   = 7'b000_1110;

    localparam glyph_t GLYPH_LC_B    = 7'b000_0011;
    localparam glyph_t GLYPH_LC_R    = 7'b010_1111;
    localparam glyph_t GLYPH_S       = 7'b001_0010;
    localparam glyph_t GLYPH_U       = 7'b100_0001;
    localparam glyph_t GLYPH_I       = 7'b111_1001;
    localparam glyph_t GLYPH_LC_I    = 7'b111_1011;
    localparam glyph_t GLYPH_LC_D    = 7'b010_0001;
    localparam glyph_t GLYPH_LC_N    = 7'b010_1011;
    localparam glyph_t GLYPH_P       = 7'b000_1100;
    localparam glyph_t GLYPH_C       = 7'b100_0110;
    localparam glyph_t GLYPH_A       = 7'b000_1000;
    localparam glyph_t GLYPH_LC_T    = 7'b000_0111;
    localparam glyph_t GLYPH_E       = 7'b000_0110;
    localparam glyph_t GLYPH_F       = 7'b000_1110;
    localparam glyph_t GLYPH_L       = 7'b100_0111;
    localparam glyph_t GLYPH_LC_M    = 7'b101_0100;
    localparam glyph_t GLYPH_O       = 7'b100_0000;

    // wide letters drawn over two digits
    localparam glyph_t GLYPH_X_LEFT  = 7'b111_0000;
    localparam glyph_t GLYPH_X_RIGHT = 7'b100_0110;
    localparam glyph_t GLYPH_M_LEFT  = 7'b100_1100;
    localparam glyph_t GLYPH_M_RIGHT = 7'b101_1000;
    localparam glyph_t GLYPH_T_LEFT  = 7'b111_1000;
    localparam glyph_t GLYPH_T_RIGHT = 7'b100_1110;

    localparam glyph_t GLYPH_ONE     = 7'b111_1001;
    localparam glyph_t GLYPH_TWO     = 7'b010_0100;

    localparam logic [PROBE_W-1:0] VIEW_BUS  = 16'd0;
    localparam logic [PROBE_W-1:0] VIEW_RA   = 16'd1;
    localparam logic [PROBE_W-1:0] VIEW_RB   = 16'd2;
    localparam logic [PROBE_W-1:0] VIEW_RC   = 16'd3;
    localparam logic [PROBE_W-1:0] VIEW_IS   = 16'd4;
    localparam logic [PROBE_W-1:0] VIEW_XA   = 16'd5;
    localparam logic [PROBE_W-1:0] VIEW_XB   = 16'd6;
    localparam logic [PROBE_W-1:0] VIEW_BA   = 16'd7;
    localparam logic [PROBE_W-1:0] VIEW_BB   = 16'd8;
    localparam logic [PROBE_W-1:0] VIEW_RI   = 16'd9;
    localparam logic [PROBE_W-1:0] VIEW_IND  = 16'd10;
    localparam logic [PROBE_W-1:0] VIEW_CP   = 16'd11;
    localparam logic [PROBE_W-1:0] VIEW_AM   = 16'd12;
    localparam logic [PROBE_W-1:0] VIEW_M    = 16'd13;
    localparam logic [PROBE_W-1:0] VIEW_T1   = 16'd14;
    localparam logic [PROBE_W-1:0] VIEW_T2   = 16'd15;
    localparam logic [PROBE_W-1:0] VIEW_FSM  = 16'd16;
    localparam logic [PROBE_W-1:0] VIEW_LAST = VIEW_FSM;

    localparam logic [3:0] PH_RESET      = 4'd0;
    localparam logic [3:0] PH_FETCH      = 4'd1;
    localparam logic [3:0] PH_DECODE     = 4'd2;
    localparam logic [3:0] PH_ADDR       = 4'd3;
    localparam logic [3:0] PH_LOAD_SRC   = 4'd4;
    localparam logic [3:0] PH_LOAD_DST   = 4'd5;
    localparam logic [3:0] PH_NOLOAD_DST = 4'd6;
    localparam logic [3:0] PH_EXEC       = 4'd7;
    localparam logic [3:0] PH_STORE      = 4'd8;
    localparam logic [3:0] PH_INC_CP     = 4'd9;

    localparam logic [1:0] VAR_REG    = 2'd1;   // addressing phase only
    localparam logic [1:0] VAR_MEM    = 2'd1;
    localparam logic [1:0] VAR_IO     = 2'd3;
    localparam logic [1:0] VAR_SUM    = 2'd0;

    localparam logic [1:0] VAR_1OP    = 2'd0;
    localparam logic [1:0] VAR_2OP    = 2'd1;
    localparam logic [1:0] VAR_TRANSF = 2'd2;

endpackage

`default_nettype wire

/* view_selector.sv */
`timescale 1ns/10ps
`default_nettype none

module view_selector (
    input  wire                                    i_w_clk,
    input  wire                                    i_w_reset_n,
    input  wire                                    i_w_next,
    input  wire                                    i_w_prev,
    output logic [state_display_pkg::PROBE_W-1:0] o_w_view
);

    logic l_r_next_last;
    logic l_r_prev_last;
    logic l_w_next_rise;
    logic l_w_prev_rise;

    assign l_w_next_rise = i_w_next && !l_r_next_last;
    assign l_w_prev_rise = i_w_prev && !l_r_prev_last;

    always_ff @(posedge i_w_clk or negedge i_w_reset_n) begin
        if (!i_w_reset_n) begin
            l_r_next_last <= 1'b0;
            l_r_prev_last <= 1'b0;
            o_w_view      <= state_display_pkg::VIEW_BUS;
        end else begin
            l_r_next_last <= i_w_next;
            l_r_prev_last <= i_w_prev;
            if (l_w_prev_rise) begin                     // prev wins a tie
                o_w_view <= (o_w_view == state_display_pkg::VIEW_BUS) ?
                            state_display_pkg::VIEW_LAST : o_w_view - 16'd1;
            end else if (l_w_next_rise) begin
                o_w_view <= (o_w_view == state_display_pkg::VIEW_LAST) ?
                            state_display_pkg::VIEW_BUS : o_w_view + 16'd1;
            end
        end
    end

endmodule

`default_nettype wire

/* register_label_rom.sv */
`timescale 1ns/10ps
`default_nettype none

module register_label_rom (
    input  wire  [state_display_pkg::PROBE_W-1:0] i_w_view,
    output state_display_pkg::glyph_quad_t        o_w_label,
    output logic                                  o_w_fsm_view
);

    assign o_w_fsm_view = (i_w_view == state_display_pkg::VIEW_FSM);

    // glyphs listed from digit 7 down to digit 4
    always_comb begin
        case (i_w_view)
            state_display_pkg::VIEW_BUS: o_w_label = {state_display_pkg::GLYPH_BLANK,
                state_display_pkg::GLYPH_LC_B, state_display_pkg::GLYPH_U,
                state_display_pkg::GLYPH_S};
            state_display_pkg::VIEW_RA: o_w_label = {{2{state_display_pkg::GLYPH_BLANK}},
                state_display_pkg::GLYPH_LC_R, state_display_pkg::GLYPH_A};
            state_display_pkg::VIEW_RB: o_w_label = {{2{state_display_pkg::GLYPH_BLANK}},
                state_display_pkg::GLYPH_LC_R, state_display_pkg::GLYPH_LC_B};
            state_display_pkg::VIEW_RC: o_w_label = {{2{state_display_pkg::GLYPH_BLANK}},
                state_display_pkg::GLYPH_LC_R, state_display_pkg::GLYPH_C};
            state_display_pkg::VIEW_IS: o_w_label = {{2{state_display_pkg::GLYPH_BLANK}},
                state_display_pkg::GLYPH_I, state_display_pkg::GLYPH_S};
            state_display_pkg::VIEW_XA: o_w_label = {state_display_pkg::GLYPH_BLANK,
                state_display_pkg::GLYPH_X_LEFT, state_display_pkg::GLYPH_X_RIGHT,
                state_display_pkg::GLYPH_A};
            state_display_pkg::VIEW_XB: o_w_label = {state_display_pkg::GLYPH_BLANK,
                state_display_pkg::GLYPH_X_LEFT, state_display_pkg::GLYPH_X_RIGHT,
                state_display_pkg::GLYPH_LC_B};
            state_display_pkg::VIEW_BA: o_w_label = {{2{state_display_pkg::GLYPH_BLANK}},
                state_display_pkg::GLYPH_LC_B, state_display_pkg::GLYPH_A};
            state_display_pkg::VIEW_BB: o_w_label = {{2{state_display_pkg::GLYPH_BLANK}},
                state_display_pkg::GLYPH_LC_B, state_display_pkg::GLYPH_LC_B};
            state_display_pkg::VIEW_RI: o_w_label = {{2{state_display_pkg::GLYPH_BLANK}},
                state_display_pkg::GLYPH_LC_R, state_display_pkg::GLYPH_I};
            state_display_pkg::VIEW_IND: o_w_label = {state_display_pkg::GLYPH_BLANK,
                state_display_pkg::GLYPH_LC_I, state_display_pkg::GLYPH_LC_N,
                state_display_pkg::GLYPH_LC_D};
            state_display_pkg::VIEW_CP: o_w_label = {{2{state_display_pkg::GLYPH_BLANK}},
                state_display_pkg::GLYPH_C, state_display_pkg::GLYPH_P};
            state_display_pkg::VIEW_AM: o_w_label = {state_display_pkg::GLYPH_BLANK,
                state_display_pkg::GLYPH_A, state_display_pkg::GLYPH_M_LEFT,
                state_display_pkg::GLYPH_M_RIGHT};
            state_display_pkg::VIEW_M: o_w_label = {{2{state_display_pkg::GLYPH_BLANK}},
                state_display_pkg::GLYPH_M_LEFT, state_display_pkg::GLYPH_M_RIGHT};
            state_display_pkg::VIEW_T1: o_w_label = {state_display_pkg::GLYPH_BLANK,
                state_display_pkg::GLYPH_T_LEFT, state_display_pkg::GLYPH_T_RIGHT,
                state_display_pkg::GLYPH_ONE};
            state_display_pkg::VIEW_T2: o_w_label = {state_display_pkg::GLYPH_BLANK,
                state_display_pkg::GLYPH_T_LEFT, state_display_pkg::GLYPH_T_RIGHT,
                state_display_pkg::GLYPH_TWO};
            state_display_pkg::VIEW_FSM: o_w_label = {state_display_pkg::GLYPH_F,
                state_display_pkg::GLYPH_S, state_display_pkg::GLYPH_M_LEFT,
                state_display_pkg::GLYPH_M_RIGHT};
            default: o_w_label = {state_display_pkg::LABEL_DIGITS{
                state_display_pkg::GLYPH_BLANK}};
        endcase
    end

endmodule

`default_nettype wire

/* fsm_mnemonic_rom.sv */
`timescale 1ns/10ps
`default_nettype none

module fsm_mnemonic_rom (
    input  wire state_display_pkg::probe_word_u  i_w_in,
    output state_display_pkg::glyph_quad_t       o_w_mnemonic
);

    logic                                  l_w_known;
    logic [1:0]                            l_w_max_step;     // highest legal micro-step
    logic [3*state_display_pkg::SEG_W-1:0] l_w_letters;      // digits 3, 2, 1
    state_display_pkg::glyph_t             l_w_step_glyph;

    always_comb begin
        {l_w_known, l_w_max_step, l_w_letters} = {1'b0, 2'd0,
            {3{state_display_pkg::GLYPH_BLANK}}};
        case ({i_w_in.state.phase, i_w_in.state.variant})
            {state_display_pkg::PH_RESET, 2'd0}: {l_w_known, l_w_max_step, l_w_letters} =
                {1'b1, 2'd0, state_display_pkg::GLYPH_LC_R, state_display_pkg::GLYPH_S,
                state_display_pkg::GLYPH_LC_T};
            {state_display_pkg::PH_FETCH, 2'd0}: {l_w_known, l_w_max_step, l_w_letters} =
                {1'b1, 2'd2, state_display_pkg::GLYPH_F, state_display_pkg::GLYPH_E,
                state_display_pkg::GLYPH_LC_T};
            {state_display_pkg::PH_DECODE, 2'd0}: {l_w_known, l_w_max_step, l_w_letters} =
                {1'b1, 2'd0, state_display_pkg::GLYPH_LC_D, state_display_pkg::GLYPH_C,
                state_display_pkg::GLYPH_LC_D};
            {state_display_pkg::PH_ADDR, state_display_pkg::VAR_SUM}:
                {l_w_known, l_w_max_step, l_w_letters} = {1'b1, 2'd2,
                state_display_pkg::GLYPH_A, state_display_pkg::GLYPH_LC_D,
                state_display_pkg::GLYPH_S};
            {state_display_pkg::PH_ADDR, state_display_pkg::VAR_REG}:
                {l_w_known, l_w_max_step, l_w_letters} = {1'b1, 2'd0,
                state_display_pkg::GLYPH_A, state_display_pkg::GLYPH_LC_D,
                state_display_pkg::GLYPH_LC_R};
            {state_display_pkg::PH_ADDR, state_display_pkg::VAR_IO}:
                {l_w_known, l_w_max_step, l_w_letters} = {1'b1, 2'd0,
                state_display_pkg::GLYPH_A, state_display_pkg::GLYPH_LC_D,
                state_display_pkg::GLYPH_I};
            {state_display_pkg::PH_LOAD_SRC, 2'd0}: {l_w_known, l_w_max_step, l_w_letters} =
                {1'b1, 2'd0, state_display_pkg::GLYPH_L, state_display_pkg::GLYPH_S,
                state_display_pkg::GLYPH_LC_R};
            {state_display_pkg::PH_LOAD_SRC, state_display_pkg::VAR_MEM}:
                {l_w_known, l_w_max_step, l_w_letters} = {1'b1, 2'd2,
                state_display_pkg::GLYPH_L, state_display_pkg::GLYPH_S,
                state_display_pkg::GLYPH_LC_M};
            {state_display_pkg::PH_LOAD_SRC, state_display_pkg::VAR_IO}:
                {l_w_known, l_w_max_step, l_w_letters} = {1'b1, 2'd1,
                state_display_pkg::GLYPH_L, state_display_pkg::GLYPH_S,
                state_display_pkg::GLYPH_I};
            {state_display_pkg::PH_LOAD_DST, 2'd0}: {l_w_known, l_w_max_step, l_w_letters} =
                {1'b1, 2'd0, state_display_pkg::GLYPH_L, state_display_pkg::GLYPH_LC_D,
                state_display_pkg::GLYPH_LC_R};
            {state_display_pkg::PH_LOAD_DST, state_display_pkg::VAR_MEM}:
                {l_w_known, l_w_max_step, l_w_letters} = {1'b1, 2'd2,
                state_display_pkg::GLYPH_L, state_display_pkg::GLYPH_LC_D,
                state_display_pkg::GLYPH_LC_M};
            {state_display_pkg::PH_NOLOAD_DST, 2'd0}:
                {l_w_known, l_w_max_step, l_w_letters} = {1'b1, 2'd0,
                state_display_pkg::GLYPH_LC_N, state_display_pkg::GLYPH_LC_D,
                state_display_pkg::GLYPH_LC_R};
            {state_display_pkg::PH_NOLOAD_DST, state_display_pkg::VAR_IO}:
                {l_w_known, l_w_max_step, l_w_letters} = {1'b1, 2'd0,
                state_display_pkg::GLYPH_LC_N, state_display_pkg::GLYPH_LC_D,
                state_display_pkg::GLYPH_I};
            {state_display_pkg::PH_EXEC, state_display_pkg::VAR_1OP}:
                {l_w_known, l_w_max_step, l_w_letters} = {1'b1, 2'd0,
                state_display_pkg::GLYPH_E, state_display_pkg::GLYPH_ONE,
                state_display_pkg::GLYPH_O};
            {state_display_pkg::PH_EXEC, state_display_pkg::VAR_2OP}:
                {l_w_known, l_w_max_step, l_w_letters} = {1'b1, 2'd0,
                state_display_pkg::GLYPH_E, state_display_pkg::GLYPH_TWO,
                state_display_pkg::GLYPH_O};
            {state_display_pkg::PH_EXEC, state_display_pkg::VAR_TRANSF}:
                {l_w_known, l_w_max_step, l_w_letters} = {1'b1, 2'd0,
                state_display_pkg::GLYPH_E, state_display_pkg::GLYPH_T_LEFT,
                state_display_pkg::GLYPH_T_RIGHT};
            {state_display_pkg::PH_STORE, 2'd0}: {l_w_known, l_w_max_step, l_w_letters} =
                {1'b1, 2'd0, state_display_pkg::GLYPH_S, state_display_pkg::GLYPH_LC_T,
                state_display_pkg::GLYPH_LC_R};
            {state_display_pkg::PH_STORE, state_display_pkg::VAR_MEM}:
                {l_w_known, l_w_max_step, l_w_letters} = {1'b1, 2'd1,
                state_display_pkg::GLYPH_S, state_display_pkg::GLYPH_LC_T,
                state_display_pkg::GLYPH_LC_M};
            {state_display_pkg::PH_STORE, state_display_pkg::VAR_IO}:
                {l_w_known, l_w_max_step, l_w_letters} = {1'b1, 2'd0,
                state_display_pkg::GLYPH_S, state_display_pkg::GLYPH_LC_T,
                state_display_pkg::GLYPH_I};
            {state_display_pkg::PH_INC_CP, 2'd0}: {l_w_known, l_w_max_step, l_w_letters} =
                {1'b1, 2'd1, state_display_pkg::GLYPH_I, state_display_pkg::GLYPH_C,
                state_display_pkg::GLYPH_P};
            default: ;                                   // unknown code stays blank
        endcase
    end

    always_comb begin
        case (i_w_in.state.step)
            2'd1:    l_w_step_glyph = state_display_pkg::GLYPH_ONE;
            2'd2:    l_w_step_glyph = state_display_pkg::GLYPH_TWO;
            default: l_w_step_glyph = state_display_pkg::GLYPH_BLANK;
        endcase
        if (l_w_known && i_w_in.state.upper == 8'd0 &&
                i_w_in.state.step <= l_w_max_step) begin
            o_w_mnemonic = {l_w_letters, l_w_step_glyph};
        end else begin
            o_w_mnemonic = {state_display_pkg::VALUE_DIGITS{state_display_pkg::GLYPH_BLANK}};
        end
    end

endmodule

`default_nettype wire

/* display_scanner.sv */
`timescale 1ns/10ps
`default_nettype none

module display_scanner (
    input  wire                                        i_w_clk,
    input  wire                                        i_w_reset_n,
    input  wire state_display_pkg::probe_word_u        i_w_in,
    input  wire state_display_pkg::glyph_quad_t        i_w_label,
    input  wire state_display_pkg::glyph_quad_t        i_w_mnemonic,
    input  wire                                        i_w_fsm_view,
    output state_display_pkg::glyph_t                  o_w_7seg,
    output logic [state_display_pkg::DIGIT_COUNT-1:0]  o_w_an
);

    logic [state_display_pkg::DIGIT_IDX_W-1:0] l_r_digit;
    logic [3:0]                                l_w_nibble;
    state_display_pkg::glyph_t                 l_w_hex;

    always_ff @(posedge i_w_clk or negedge i_w_reset_n) begin
        if (!i_w_reset_n) begin
            l_r_digit <= '0;
        end else begin
            l_r_digit <= l_r_digit + 3'd1;               // wraps after digit 7
        end
    end

    assign o_w_an     = ~(8'b0000_0001 << l_r_digit);   // one cold
    assign l_w_nibble = i_w_in.nibbles[l_r_digit[1:0]];

    always_comb begin
        case (l_w_nibble)
            4'h0: l_w_hex = state_display_pkg::GLYPH_HEX_0;
            4'h1: l_w_hex = state_display_pkg::GLYPH_HEX_1;
            4'h2: l_w_hex = state_display_pkg::GLYPH_HEX_2;
            4'h3: l_w_hex = state_display_pkg::GLYPH_HEX_3;
            4'h4: l_w_hex = state_display_pkg::GLYPH_HEX_4;
            4'h5: l_w_hex = state_display_pkg::GLYPH_HEX_5;
            4'h6: l_w_hex = state_display_pkg::GLYPH_HEX_6;
            4'h7: l_w_hex = state_display_pkg::GLYPH_HEX_7;
            4'h8: l_w_hex = state_display_pkg::GLYPH_HEX_8;
            4'h9: l_w_hex = state_display_pkg::GLYPH_HEX_9;
            4'hA: l_w_hex = state_display_pkg::GLYPH_HEX_A;
            4'hB: l_w_hex = state_display_pkg::GLYPH_HEX_B;
            4'hC: l_w_hex = state_display_pkg::GLYPH_HEX_C;
            4'hD: l_w_hex = state_display_pkg::GLYPH_HEX_D;
            4'hE: l_w_hex = state_display_pkg::GLYPH_HEX_E;
            4'hF: l_w_hex = state_display_pkg::GLYPH_HEX_F;
        endcase
    end

    always_comb begin
        if (l_r_digit[2]) begin
            o_w_7seg = i_w_label[l_r_digit[1:0]];        // upper four digits
        end else if (i_w_fsm_view) begin
            o_w_7seg = i_w_mnemonic[l_r_digit[1:0]];
        end else begin
            o_w_7seg = l_w_hex;
        end
    end

endmodule

`default_nettype wire

/* state_display.sv */
`timescale 1ns/10ps
`default_nettype none

module state_display (
    input  wire                                        i_w_clk,
    input  wire                                        i_w_reset_n,
    input  wire                                        i_w_next,
    input  wire                                        i_w_prev,
    input  wire  [state_display_pkg::PROBE_W-1:0]      i_w_in,
    output logic [state_display_pkg::SEG_W-1:0]        o_w_7seg,
    output logic [state_display_pkg::DIGIT_COUNT-1:0]  o_w_an,
    output logic [state_display_pkg::PROBE_W-1:0]      o_w_state
);

    logic [state_display_pkg::PROBE_W-1:0] l_w_view;
    state_display_pkg::glyph_quad_t        l_w_label;
    state_display_pkg::glyph_quad_t        l_w_mnemonic;
    logic                                  l_w_fsm_view;

    assign o_w_state = l_w_view;

    view_selector i_view_selector (
        .i_w_clk      (i_w_clk),
        .i_w_reset_n  (i_w_reset_n),
        .i_w_next     (i_w_next),
        .i_w_prev     (i_w_prev),
        .o_w_view     (l_w_view)
    );

    register_label_rom i_register_label_rom (
        .i_w_view     (l_w_view),
        .o_w_label    (l_w_label),
        .o_w_fsm_view (l_w_fsm_view)
    );

    fsm_mnemonic_rom i_fsm_mnemonic_rom (
        .i_w_in       (i_w_in),
        .o_w_mnemonic (l_w_mnemonic)
    );

    display_scanner i_display_scanner (
        .i_w_clk      (i_w_clk),
        .i_w_reset_n  (i_w_reset_n),
        .i_w_in       (i_w_in),
        .i_w_label    (l_w_label),
        .i_w_mnemonic (l_w_mnemonic),
        .i_w_fsm_view (l_w_fsm_view),
        .o_w_7seg     (o_w_7seg),
        .o_w_an       (o_w_an)
    );

endmodule

`default_nettype wire

/* tb_state_display.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_state_display;

    localparam int MAX_VECTORS = 64;
    localparam int NAME_W      = 8*24;

    logic        clk = 1'b0;
    logic        reset_n;
    logic        next_btn;
    logic        prev_btn;
    logic [15:0] probe;
    logic [6:0]  seg;
    logic [7:0]  an;
    logic [15:0] view;

    string       vec_name  [0:MAX_VECTORS-1];
    logic        vec_next  [0:MAX_VECTORS-1];
    logic        vec_prev  [0:MAX_VECTORS-1];
    logic [15:0] vec_probe [0:MAX_VECTORS-1];
    logic [15:0] vec_view  [0:MAX_VECTORS-1];
    logic [6:0]  vec_glyph [0:MAX_VECTORS-1][0:7];   // indexed by digit

    integer vec_count    = 0;
    integer value_errors = 0;
    integer other_errors = 0;
    integer cycle_count  = 0;
    integer cycle_limit  = 100;
    integer seed         = 32'h1067;

    state_display i_dut (
        .i_w_clk     (clk),
        .i_w_reset_n (reset_n),
        .i_w_next    (next_btn),
        .i_w_prev    (prev_btn),
        .i_w_in      (probe),
        .o_w_7seg    (seg),
        .o_w_an      (an),
        .o_w_state   (view)
    );

    always #10 clk = ~clk;

    task automatic report_counts;
        $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            other_errors = other_errors + 1;
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            report_counts();
            $display("Finished with errors");
            $finish;
        end
    end

    task automatic check_value(input string test_name, input string what,
                               input logic [15:0] expected, input logic [15:0] actual);
        if (expected !== actual) begin
            value_errors = value_errors + 1;
            $display("[ERROR] %s %s: expected %h, actual %h", test_name, what, expected, actual);
        end
    endtask

    // -1 unless exactly one anode is low
    function automatic integer lit_digit(input logic [7:0] anodes);
        integer k;
        integer zeros;
        integer idx;
        zeros = 0;
        idx   = -1;
        for (k = 0; k < 8; k++) begin
            if (!anodes[k[2:0]]) begin
                zeros = zeros + 1;
                idx   = k;
            end
        end
        if (zeros != 1) idx = -1;
        return idx;
    endfunction

    task automatic load_golden(output logic ok);
        integer           fd;
        integer           code;
        integer           fields;
        integer           k;
        logic [8*128-1:0] line;
        logic [NAME_W-1:0] name_tmp;
        integer           next_tmp;
        integer           prev_tmp;
        integer           probe_tmp;
        integer           view_tmp;
        integer           g [0:7];
        ok = 1'b0;
        fd = $fopen("state_display_golden.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                code = $fgets(line, fd);
                if (code > 0) begin
                    fields = $sscanf(line, "%s %d %d %h %d %h %h %h %h %h %h %h %h",
                                     name_tmp, next_tmp, prev_tmp, probe_tmp, view_tmp,
                                     g[7], g[6], g[5], g[4], g[3], g[2], g[1], g[0]);
                    if (fields == 13 && vec_count < MAX_VECTORS) begin   // comments skipped
                        vec_name[vec_count[5:0]]  = $sformatf("%0s", name_tmp);
                        vec_next[vec_count[5:0]]  = next_tmp[0];
                        vec_prev[vec_count[5:0]]  = prev_tmp[0];
                        vec_probe[vec_count[5:0]] = probe_tmp[15:0];
                        vec_view[vec_count[5:0]]  = view_tmp[15:0];
                        for (k = 0; k < 8; k++) begin
                            vec_glyph[vec_count[5:0]][k[2:0]] = g[k[2:0]][6:0];
                        end
                        vec_count = vec_count + 1;
                    end
                end
            end
            $fclose(fd);
            ok = (vec_count > 0);
        end
    endtask

    task automatic run_vector(input integer n);
        integer     gap;
        integer     k;
        integer     lit;
        logic [7:0] seen;
        string      name;
        seen = 8'h00;
        name = vec_name[n[5:0]];
        gap  = $random(seed) & 3;
        repeat (gap) @(posedge clk);
        @(posedge clk);
        probe <= vec_probe[n[5:0]];
        if (vec_next[n[5:0]] || vec_prev[n[5:0]]) begin
            @(posedge clk);
            next_btn <= vec_next[n[5:0]];
            prev_btn <= vec_prev[n[5:0]];
            repeat (2) @(posedge clk);                   // held but steps once
            next_btn <= 1'b0;
            prev_btn <= 1'b0;
            repeat (2) @(posedge clk);
        end
        @(negedge clk);
        check_value(name, "view", vec_view[n[5:0]], view);
        for (k = 0; k < 8; k++) begin
            if (k != 0) @(negedge clk);
            lit = lit_digit(an);
            if (lit < 0) begin
                other_errors = other_errors + 1;
                $display("%s: anode pattern %b does not light exactly one digit", name, an);
            end else begin
                seen[lit[2:0]] = 1'b1;
                check_value(name, $sformatf("digit %0d", lit),
                            {9'd0, vec_glyph[n[5:0]][lit[2:0]]}, {9'd0, seg});
            end
        end
        if (seen != 8'hFF) begin
            other_errors = other_errors + 1;
            $display("%s: the scan skipped a digit, digits seen %b", name, seen);
        end
    endtask

    initial begin
        logic   ok;
        integer n;
        reset_n  = 1'b0;
        next_btn = 1'b0;
        prev_btn = 1'b0;
        probe    = 16'h0000;
        load_golden(ok);
        if (!ok) begin
            other_errors = other_errors + 1;
            $display("the golden file state_display_golden.txt is missing or holds no vectors");
            report_counts();
            $display("Finished with errors");
            $finish;
        end else begin
            cycle_limit = vec_count * 16 + 100;
            repeat (3) @(posedge clk);
            reset_n <= 1'b1;
            @(negedge clk);
            check_value("reset", "view", 16'h0000, view);
            check_value("reset", "anode", 16'h00FE, {8'h00, an});   // digit 0 first
            for (n = 0; n < vec_count; n++) begin
                run_vector(n);
            end
            report_counts();
            if (value_errors == 0 && other_errors == 0) begin
                $display("Finished with no errors");
            end else begin
                $display("Finished with errors");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

/* state_display_golden.txt */
# columns: name next prev probe(hex) view(dec) then eight glyphs in hex for digits 7 down to 0
# glyphs are active low with segment g at bit 6, 7F is a blank digit
reset_bus 0 0 0000 0 7F 03 41 12 40 40 40 40
next_ra 1 0 1A2F 1 7F 7F 2F 08 79 08 24 0E
next_rb 1 0 BEEF 2 7F 7F 2F 03 03 06 06 0E
next_rc 1 0 0123 3 7F 7F 2F 46 40 79 24 30
next_is 1 0 4567 4 7F 7F 79 12 19 12 02 78
next_xa 1 0 89AB 5 7F 70 46 08 00 18 08 03
next_xb 1 0 CDEF 6 7F 70 46 03 46 21 06 0E
next_ba 1 0 0000 7 7F 7F 03 08 40 40 40 40
next_bb 1 0 FFFF 8 7F 7F 03 03 0E 0E 0E 0E
next_ri 1 0 5A5A 9 7F 7F 2F 79 12 08 12 08
next_ind 1 0 1234 10 7F 7B 2B 21 79 24 30 19
next_cp 1 0 00FF 11 7F 7F 46 0C 40 40 0E 0E
next_am 1 0 8001 12 7F 08 4C 58 00 40 40 79
next_m 1 0 7E3C 13 7F 7F 4C 58 78 06 30 46
next_t1 1 0 0F0F 14 7F 78 4E 79 40 0E 40 0E
next_t2 1 0 9999 15 7F 78 4E 24 18 18 18 18
fsm_reset 1 0 0000 16 0E 12 4C 58 2F 12 07 7F
fsm_fetch_2 0 0 0012 16 0E 12 4C 58 0E 06 07 24
fsm_addr_reg 0 0 0034 16 0E 12 4C 58 08 21 2F 7F
fsm_exec_transf 0 0 0078 16 0E 12 4C 58 06 78 4E 7F
fsm_inc_cp_1 0 0 0091 16 0E 12 4C 58 79 46 0C 79
unknown_0013 0 0 0013 16 0E 12 4C 58 7F 7F 7F 7F
unknown_0036 0 0 0036 16 0E 12 4C 58 7F 7F 7F 7F
unknown_0100 0 0 0100 16 0E 12 4C 58 7F 7F 7F 7F
wrap_next 1 0 0000 0 7F 03 41 12 40 40 40 40
wrap_prev 0 1 0091 16 0E 12 4C 58 79 46 0C 79
both_buttons 1 1 ABCD 15 7F 78 4E 24 08 03 46 21
prev_t1 0 1 0000 14 7F 78 4E 79 40 40 40 40

/* flist.f */
state_display_pkg.sv
view_selector.sv
register_label_rom.sv
fsm_mnemonic_rom.sv
display_scanner.sv
state_display.sv
tb_state_display.sv

/* run.sh */
#!/bin/sh
# build and run the state display testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --timescale 1ns/10ps -f flist.f \
    --top-module tb_state_display -o sim_state_display
output=$(./obj_dir/sim_state_display)
echo "$output"
if echo "$output" | grep -q "^Finished with no errors$"; then
    exit 0
fi
exit 1
